/* rtl/jsp_cfg_pkg.sv */
////////////////////////////////////////////////////////////
// JTAG serial port configuration
// Widths and data types shared by the byte, count and bit
// position logic of the serial port
////////////////////////////////////////////////////////////

package jsp_cfg_pkg;

  ////////////////////////////////////////////////////////////
  // Widths

  localparam int unsigned BYTE_W    = 8;  // One transferred byte
  localparam int unsigned COUNT_W   = 4;  // FIFO and user byte counts
  localparam int unsigned BIT_IDX_W = $clog2(BYTE_W);

  // Data register bits seen by the port, one short of a byte
  // since TDI supplies the newest bit itself
  localparam int unsigned DR_TAIL_W = BYTE_W - 1;

  ////////////////////////////////////////////////////////////
  // Types

  typedef logic [BYTE_W-1:0]    byte_t;     // Data or count byte
  typedef logic [COUNT_W-1:0]   count_t;    // Nibble wide byte count
  typedef logic [BIT_IDX_W-1:0] bit_idx_t;  // Bit position in a byte

  // Index of the eighth bit of a byte
  localparam bit_idx_t BIT_LAST = bit_idx_t'(BYTE_W - 1);

endpackage : jsp_cfg_pkg

/* rtl/jsp_ctrl_pkg.sv */
////////////////////////////////////////////////////////////
// JTAG serial port control encodings
// State enumerations of the input and output sequencers and
// the next-value select of the byte counters
////////////////////////////////////////////////////////////

package jsp_ctrl_pkg;

  ////////////////////////////////////////////////////////////
  // Input path states (host to FIFO)

  typedef enum logic [1:0] {
    WR_IDLE   = 2'd0,  // Waiting for capture
    WR_WAIT   = 2'd1,  // Waiting for the start bit
    WR_COUNTS = 2'd2,  // Shifting in the count byte
    WR_XFER   = 2'd3   // Shifting in data bytes
  } wr_state_e;

  ////////////////////////////////////////////////////////////
  // Output path states (FIFO to host)

  typedef enum logic [1:0] {
    RD_IDLE   = 2'd0,  // Waiting for capture
    RD_COUNTS = 2'd1,  // Shifting out the count byte
    RD_RDACK  = 2'd2,  // First bit of a byte, pop the FIFO head
    RD_XFER   = 2'd3   // Rest of a data byte
  } rd_state_e;

  ////////////////////////////////////////////////////////////
  // Counter next-value source

  typedef enum logic {
    CNT_LOAD = 1'b0,  // Take the external value
    CNT_DEC  = 1'b1   // Count down by one
  } cnt_src_e;

endpackage : jsp_ctrl_pkg

/* rtl/jsp_bit_counter.sv */
////////////////////////////////////////////////////////////
// JTAG serial port bit counter
// Tracks the bit position within the byte being shifted
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module jsp_bit_counter
  import jsp_cfg_pkg::*;
(
  input  logic tck_i,
  input  logic rst_i,
  input  logic clr_i,   // Back to bit zero
  input  logic en_i,    // Advance one bit
  output logic last_o   // Eighth bit of the byte
);

  bit_idx_t bit_cnt;  // Bits shifted so far in this byte

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      bit_cnt <= '0;
    end else if (clr_i) begin  // Clear wins over enable
      bit_cnt <= '0;
    end else if (en_i) begin
      bit_cnt <= bit_cnt + bit_idx_t'(1);
    end
  end

  assign last_o = (bit_cnt == BIT_LAST);

endmodule : jsp_bit_counter

/* rtl/jsp_word_counter.sv */
////////////////////////////////////////////////////////////
// JTAG serial port byte counter
// Loadable down counter for FIFO space, FIFO fill level and
// the host's own byte count
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module jsp_word_counter
  import jsp_cfg_pkg::*, jsp_ctrl_pkg::*;
(
  input  logic     tck_i,
  input  logic     rst_i,
  input  logic     ld_i,        // Update the count
  input  cnt_src_e src_i,       // Load value or decrement
  input  count_t   load_val_i,  // External start value
  output logic     zero_o       // Nothing left
);

  count_t word_cnt;  // Bytes remaining
  count_t next_cnt;  // Value taken on ld_i

  // Next value mux
  always_comb begin
    if (src_i == CNT_DEC) begin
      next_cnt = word_cnt - count_t'(1);
    end else begin
      next_cnt = load_val_i;
    end
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      word_cnt <= '0;
    end else if (ld_i) begin
      word_cnt <= next_cnt;
    end
  end

  assign zero_o = (word_cnt == '0);  // Blocks further transfers

endmodule : jsp_word_counter

/* rtl/jsp_out_shift.sv */
////////////////////////////////////////////////////////////
// JTAG serial port output register
// Parallel load of a count or data byte, shifted out LSB
// first onto TDO
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module jsp_out_shift
  import jsp_cfg_pkg::*;
(
  input  logic  tck_i,
  input  logic  rst_i,
  input  logic  ld_i,          // Parallel load
  input  logic  shift_i,       // Shift right by one
  input  logic  sel_count_i,   // 1 = count byte, 0 = FIFO byte
  input  byte_t count_byte_i,  // Bytes available and space free
  input  byte_t data_byte_i,   // FIFO head
  output logic  tdo_o
);

  byte_t out_reg;   // Byte being shifted out
  byte_t load_val;  // Parallel input

  assign load_val = sel_count_i ? count_byte_i : data_byte_i;

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      out_reg <= '0;
    end else if (ld_i) begin  // Load beats shift
      out_reg <= load_val;
    end else if (shift_i) begin
      out_reg <= {1'b0, out_reg[BYTE_W-1:1]};  // Zeros fill from the top
    end
  end

  assign tdo_o = out_reg[0];  // LSB goes out first

endmodule : jsp_out_shift

/* rtl/jsp_wr_fsm.sv */
////////////////////////////////////////////////////////////
// JTAG serial port input sequencer
// Waits for the start bit, takes the host's count byte and
// strobes data bytes into the FIFO while counts allow
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module jsp_wr_fsm
  import jsp_ctrl_pkg::*;
#(
  parameter bit SUPPORT_MULTI = 1'b1  // Wait for a start bit first
) (
  input  logic     tck_i,
  input  logic     rst_i,
  input  logic     capture_dr_i,
  input  logic     shift_dr_i,
  input  logic     update_dr_i,
  input  logic     module_select_i,
  input  logic     tdi_i,
  input  logic     bit_last_i,    // Eighth bit of the byte
  input  logic     in_zero_i,     // FIFO full as of capture
  input  logic     user_zero_i,   // Host count used up
  output logic     bit_clr_o,
  output logic     bit_en_o,
  output logic     in_ld_o,
  output logic     user_ld_o,
  output logic     wr_strobe_o,   // BIU latches the byte at next edge
  output cnt_src_e in_src_o,
  output cnt_src_e user_src_o
);

  wr_state_e state_q;
  wr_state_e state_d;
  logic      start;     // Capture with this module selected
  logic      byte_end;  // Eighth shift of a byte

  assign start    = capture_dr_i && module_select_i;
  assign byte_end = shift_dr_i && bit_last_i;

  ////////////////////////////////////////////////////////////
  // State register and next state

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= WR_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      WR_IDLE: begin
        if (start) begin
          state_d = SUPPORT_MULTI ? WR_WAIT : WR_COUNTS;
        end
      end
      WR_WAIT: begin
        if (update_dr_i) begin
          state_d = WR_IDLE;
        end else if (module_select_i && tdi_i) begin
          state_d = WR_COUNTS;  // Start bit seen, not counted
        end
      end
      WR_COUNTS: begin
        if (update_dr_i) begin
          state_d = WR_IDLE;
        end else if (byte_end) begin
          state_d = WR_XFER;
        end
      end
      WR_XFER: begin
        if (update_dr_i) state_d = WR_IDLE;  // Stays here until update
      end
      default: state_d = WR_IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Decoded outputs

  always_comb begin
    bit_clr_o   = 1'b0;
    bit_en_o    = 1'b0;
    in_ld_o     = 1'b0;
    user_ld_o   = 1'b0;
    wr_strobe_o = 1'b0;
    in_src_o    = CNT_LOAD;
    user_src_o  = CNT_LOAD;
    case (state_q)
      WR_IDLE: begin
        if (start) begin
          bit_clr_o = 1'b1;
          in_ld_o   = 1'b1;  // Snapshot of FIFO space
        end
      end
      WR_COUNTS: begin
        bit_en_o  = shift_dr_i;  // PAUSE and EXIT do nothing
        bit_clr_o = byte_end;
        user_ld_o = byte_end;    // Upper nibble of the count byte
      end
      WR_XFER: begin
        in_src_o   = CNT_DEC;
        user_src_o = CNT_DEC;
        bit_en_o   = shift_dr_i;
        if (byte_end) begin
          bit_clr_o = 1'b1;
          // Write only while both space and host count remain
          if (!in_zero_i && !user_zero_i) begin
            wr_strobe_o = 1'b1;
            in_ld_o     = 1'b1;
            user_ld_o   = 1'b1;
          end
        end
      end
      default: ;  // WAIT only watches for the start bit
    endcase
  end

endmodule : jsp_wr_fsm

/* rtl/jsp_rd_fsm.sv */
////////////////////////////////////////////////////////////
// JTAG serial port output sequencer
// Shifts out the count byte, then FIFO bytes, acknowledging
// each byte on its first bit
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module jsp_rd_fsm
  import jsp_ctrl_pkg::*;
(
  input  logic     tck_i,
  input  logic     rst_i,
  input  logic     capture_dr_i,
  input  logic     shift_dr_i,
  input  logic     update_dr_i,
  input  logic     module_select_i,
  input  logic     bit_last_i,       // Eighth bit of the byte
  input  logic     out_zero_i,       // No FIFO bytes left to show
  output logic     bit_clr_o,
  output logic     bit_en_o,
  output logic     out_ld_o,
  output logic     reg_ld_o,
  output logic     reg_shift_o,
  output logic     reg_sel_count_o,  // Load the count byte
  output logic     rd_strobe_o,      // BIU pops the head at next edge
  output cnt_src_e out_src_o
);

  rd_state_e state_q;
  rd_state_e state_d;
  logic      start;     // Capture with this module selected
  logic      byte_end;  // Eighth shift of a byte

  assign start    = capture_dr_i && module_select_i;
  assign byte_end = shift_dr_i && bit_last_i;

  ////////////////////////////////////////////////////////////
  // State register and next state

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= RD_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // No start bit on this side, the host just discards the offset
  always_comb begin
    state_d = state_q;
    case (state_q)
      RD_IDLE: begin
        if (start) state_d = RD_COUNTS;
      end
      RD_COUNTS, RD_XFER: begin
        if (update_dr_i) begin
          state_d = RD_IDLE;
        end else if (byte_end) begin
          state_d = RD_RDACK;
        end
      end
      RD_RDACK: begin
        if (update_dr_i) begin
          state_d = RD_IDLE;
        end else if (shift_dr_i) begin
          state_d = RD_XFER;  // Ack done on the first bit
        end
      end
      default: state_d = RD_IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Decoded outputs

  always_comb begin
    bit_clr_o       = 1'b0;
    bit_en_o        = 1'b0;
    out_ld_o        = 1'b0;
    reg_ld_o        = 1'b0;
    reg_shift_o     = 1'b0;
    reg_sel_count_o = 1'b0;
    rd_strobe_o     = 1'b0;
    out_src_o       = CNT_LOAD;
    case (state_q)
      RD_IDLE: begin
        reg_sel_count_o = 1'b1;
        if (start) begin
          reg_ld_o  = 1'b1;  // Count byte on TDO from next cycle
          bit_clr_o = 1'b1;
          out_ld_o  = 1'b1;  // Snapshot of bytes available
        end
      end
      RD_COUNTS: begin
        bit_en_o    = shift_dr_i;
        reg_shift_o = shift_dr_i;
        if (byte_end) begin
          bit_clr_o = 1'b1;
          // Fetch the head now, the pop waits for RDACK
          if (!out_zero_i) begin
            reg_ld_o    = 1'b1;
            reg_shift_o = 1'b0;
          end
        end
      end
      RD_RDACK: begin
        bit_en_o    = shift_dr_i;
        reg_shift_o = shift_dr_i;
        rd_strobe_o = shift_dr_i && !out_zero_i;  // Never the last bit here
      end
      RD_XFER: begin
        out_src_o   = CNT_DEC;
        bit_en_o    = shift_dr_i;
        reg_shift_o = shift_dr_i;
        if (byte_end) begin
          bit_clr_o = 1'b1;
          if (!out_zero_i) begin
            reg_ld_o    = 1'b1;
            reg_shift_o = 1'b0;
            out_ld_o    = 1'b1;  // One more byte consumed
          end
        end
      end
      default: ;
    endcase
  end

endmodule : jsp_rd_fsm

/* rtl/jsp_serial_port.sv */
////////////////////////////////////////////////////////////
// JTAG serial port
// Byte stream between the host and the BIU FIFO, carried in
// the JTAG data register
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module jsp_serial_port
  import jsp_cfg_pkg::*, jsp_ctrl_pkg::*;
#(
  parameter bit SUPPORT_MULTI = 1'b1  // Start bit for multi-device chains
) (
  input  logic                 tck_i,
  input  logic                 rst_i,
  // TAP levels
  input  logic                 capture_dr_i,
  input  logic                 shift_dr_i,
  input  logic                 update_dr_i,
  input  logic                 module_select_i,
  input  logic                 tdi_i,
  input  logic [DR_TAIL_W-1:0] dr_tail_i,  // Latest data register bits
  output logic                 tdo_o,
  // BIU side
  input  byte_t                biu_rd_data_i,      // FIFO head
  input  count_t               biu_bytes_avail_i,
  input  count_t               biu_space_free_i,
  output byte_t                biu_wr_data_o,
  output logic                 biu_wr_strobe_o,
  output logic                 biu_rd_strobe_o
);

  ////////////////////////////////////////////////////////////
  // Internal signals

  // Input path
  logic     wr_bit_clr, wr_bit_en, wr_bit_last;
  logic     in_ld, in_zero;
  logic     user_ld, user_zero;
  cnt_src_e in_src, user_src;
  count_t   user_count_in;  // Upper nibble of the host's count byte

  // Output path
  logic     rd_bit_clr, rd_bit_en, rd_bit_last;
  logic     out_ld, out_zero;
  cnt_src_e out_src;
  logic     reg_ld, reg_shift, reg_sel_count;
  byte_t    count_byte;     // Fill level over free space

  assign count_byte    = {biu_bytes_avail_i, biu_space_free_i};
  assign user_count_in = {tdi_i, dr_tail_i[DR_TAIL_W-1 -: COUNT_W-1]};
  assign biu_wr_data_o = {tdi_i, dr_tail_i};  // Full byte on its eighth shift

  ////////////////////////////////////////////////////////////
  // Input path, host to FIFO

  jsp_wr_fsm #(.SUPPORT_MULTI(SUPPORT_MULTI)) wr_fsm_i (
    .tck_i, .rst_i, .capture_dr_i, .shift_dr_i, .update_dr_i, .module_select_i, .tdi_i,
    .bit_last_i (wr_bit_last),
    .in_zero_i  (in_zero),
    .user_zero_i(user_zero),
    .bit_clr_o  (wr_bit_clr),
    .bit_en_o   (wr_bit_en),
    .in_ld_o    (in_ld),
    .user_ld_o  (user_ld),
    .wr_strobe_o(biu_wr_strobe_o),
    .in_src_o   (in_src),
    .user_src_o (user_src)
  );

  jsp_bit_counter wr_bit_cnt_i (
    .tck_i, .rst_i, .clr_i(wr_bit_clr), .en_i(wr_bit_en), .last_o(wr_bit_last)
  );

  // Free FIFO space
  jsp_word_counter in_cnt_i (
    .tck_i, .rst_i, .ld_i(in_ld), .src_i(in_src),
    .load_val_i(biu_space_free_i), .zero_o(in_zero)
  );

  // Bytes the host says it sends
  jsp_word_counter user_cnt_i (
    .tck_i, .rst_i, .ld_i(user_ld), .src_i(user_src),
    .load_val_i(user_count_in), .zero_o(user_zero)
  );

  ////////////////////////////////////////////////////////////
  // Output path, FIFO to host

  jsp_rd_fsm rd_fsm_i (
    .tck_i, .rst_i, .capture_dr_i, .shift_dr_i, .update_dr_i, .module_select_i,
    .bit_last_i     (rd_bit_last),
    .out_zero_i     (out_zero),
    .bit_clr_o      (rd_bit_clr),
    .bit_en_o       (rd_bit_en),
    .out_ld_o       (out_ld),
    .reg_ld_o       (reg_ld),
    .reg_shift_o    (reg_shift),
    .reg_sel_count_o(reg_sel_count),
    .rd_strobe_o    (biu_rd_strobe_o),
    .out_src_o      (out_src)
  );

  jsp_bit_counter rd_bit_cnt_i (
    .tck_i, .rst_i, .clr_i(rd_bit_clr), .en_i(rd_bit_en), .last_o(rd_bit_last)
  );

  // Bytes still to show from the FIFO
  jsp_word_counter out_cnt_i (
    .tck_i, .rst_i, .ld_i(out_ld), .src_i(out_src),
    .load_val_i(biu_bytes_avail_i), .zero_o(out_zero)
  );

  jsp_out_shift out_shift_i (
    .tck_i, .rst_i,
    .ld_i        (reg_ld),
    .shift_i     (reg_shift),
    .sel_count_i (reg_sel_count),
    .count_byte_i(count_byte),
    .data_byte_i (biu_rd_data_i),
    .tdo_o
  );

endmodule : jsp_serial_port

/* verification/tb_jsp_serial_port.sv */
////////////////////////////////////////////////////////////
// JTAG serial port testbench
// Models the TAP, data register and BIU FIFO, runs read and
// write transfers and checks them with assertions
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_jsp_serial_port
  import jsp_cfg_pkg::*;
();

  logic                 tck, rst;
  logic                 capture_dr, shift_dr, update_dr, module_select, tdi, tdo;
  logic [DR_TAIL_W-1:0] dr_tail;
  byte_t                biu_rd_data = '0;  // FIFO head, owned by the FIFO model
  byte_t                biu_wr_data;
  count_t               biu_bytes_avail, biu_space_free;
  logic                 biu_wr_strobe, biu_rd_strobe;

  logic [52:0] dr_model;    // Host side data register
  byte_t       rd_q[$];     // FIFO contents the host reads
  byte_t       wr_log[$];   // Bytes written into the FIFO
  int          rd_strobes;  // Total read strobes seen
  int          value_errs;
  int          proto_errs;
  bit          timed_out;

  jsp_serial_port #(.SUPPORT_MULTI(1'b1)) dut_i (
    .tck_i            (tck),
    .rst_i            (rst),
    .capture_dr_i     (capture_dr),
    .shift_dr_i       (shift_dr),
    .update_dr_i      (update_dr),
    .module_select_i  (module_select),
    .tdi_i            (tdi),
    .dr_tail_i        (dr_tail),
    .tdo_o            (tdo),
    .biu_rd_data_i    (biu_rd_data),
    .biu_bytes_avail_i(biu_bytes_avail),
    .biu_space_free_i (biu_space_free),
    .biu_wr_data_o    (biu_wr_data),
    .biu_wr_strobe_o  (biu_wr_strobe),
    .biu_rd_strobe_o  (biu_rd_strobe)
  );

  initial begin
    tck = 1'b0;
    forever #2 tck = ~tck;  // 4 ns period
  end

  ////////////////////////////////////////////////////////////
  // TAP data register and FIFO models

  always @(posedge tck) begin
    if (shift_dr) dr_model <= {tdi, dr_model[52:1]};  // TDI enters at the top
  end
  assign dr_tail = dr_model[52 -: DR_TAIL_W];  // Newest seven bits

  always @(posedge tck) begin
    if (biu_rd_strobe) begin
      if (rd_q.size() > 0) void'(rd_q.pop_front());
      rd_strobes++;
    end
    if (biu_wr_strobe) wr_log.push_back(biu_wr_data);
    biu_rd_data <= (rd_q.size() > 0) ? rd_q[0] : '0;  // Empty FIFO reads zero
  end

  ////////////////////////////////////////////////////////////
  // Protocol assertions

  assert property (@(posedge tck) rst |-> (!tdo && !biu_wr_strobe && !biu_rd_strobe))
    else begin
      proto_errs++;
      $display("TDO or a strobe was high during reset");
    end

  assert property (@(posedge tck) disable iff (rst)
                   !shift_dr |-> (!biu_wr_strobe && !biu_rd_strobe))
    else begin
      proto_errs++;
      $display("A strobe fired in a cycle without shift");
    end

  ////////////////////////////////////////////////////////////
  // Helpers

  task automatic check_val(input string name, input int unsigned exp, input int unsigned act);
    assert (exp == act) else begin
      value_errs++;
      $display("Error: %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  function automatic int min3(input int a, input int b, input int c);
    int m;
    m = (a < b) ? a : b;
    return (m < c) ? m : c;
  endfunction

  // All cycle tasks start and end 1 ns after a rising edge
  task automatic idle_cycle();
    capture_dr = 1'b0;
    shift_dr   = 1'b0;
    update_dr  = 1'b0;
    tdi        = 1'b0;
    @(posedge tck);
    #1;
  endtask

  task automatic capture_cycle();
    capture_dr = 1'b1;
    @(posedge tck);
    #1;
    capture_dr = 1'b0;
  endtask

  task automatic update_cycle();
    update_dr = 1'b1;
    @(posedge tck);
    #1;
    update_dr = 1'b0;
  endtask

  task automatic shift_bit(input logic b, output logic t);
    shift_dr = 1'b1;
    tdi      = b;
    #1 t = tdo;  // Mid cycle, TDO is stable
    @(posedge tck);
    #1;
  endtask

  task automatic shift_byte(input byte_t b, output byte_t got);
    logic t;
    for (int i = 0; i < BYTE_W; i++) begin  // LSB first
      shift_bit(b[i], t);
      got[i] = t;
    end
  endtask

  task automatic wait_writes(input int exp);
    int cyc;
    cyc = 0;
    while (wr_log.size() < exp && cyc < 50) begin
      @(posedge tck);
      #1;
      cyc++;
    end
    if (wr_log.size() < exp) begin
      $display("Timed out waiting for %0d FIFO writes", exp);
      timed_out = 1'b1;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Read transfer, FIFO to host

  task automatic read_test(input string name, input int n, input int k);
    byte_t  exp_q[$];
    byte_t  got;
    count_t f;
    int     strobes0;
    f = count_t'($urandom_range(0, 15));
    biu_space_free  = f;
    biu_bytes_avail = count_t'(n);
    rd_q.delete();
    for (int i = 0; i < n; i++) rd_q.push_back(byte_t'($urandom));
    exp_q = rd_q;
    idle_cycle();  // Lets the head reach the DUT
    strobes0 = rd_strobes;
    capture_cycle();
    shift_byte(8'h00, got);
    check_val({name, " count byte"}, {count_t'(n), f}, got);
    for (int i = 0; i < k; i++) begin
      shift_byte(8'h00, got);
      check_val($sformatf("%s byte %0d", name, i), (i < n) ? exp_q[i] : 8'h00, got);
    end
    idle_cycle();   // EXIT
    update_cycle();
    idle_cycle();
    check_val({name, " read strobes"}, min3(k, n, 16), rd_strobes - strobes0);
    rd_q.delete();
  endtask

  ////////////////////////////////////////////////////////////
  // Write transfer, host to FIFO

  task automatic write_test(input string name, input int u, input int f,
                            input int n, input int stop);
    byte_t data[$];
    byte_t got;
    byte_t cur;
    logic  t;
    int    exp;
    biu_space_free  = count_t'(f);
    biu_bytes_avail = '0;  // No reads in the way
    wr_log.delete();
    for (int i = 0; i < n; i++) data.push_back(byte_t'($urandom));
    idle_cycle();
    capture_cycle();
    shift_bit(1'b1, t);  // Start bit right away
    shift_byte({count_t'(u), count_t'($urandom_range(0, 15))}, got);
    for (int i = 0; i < n; i++) begin
      if (i == stop) begin  // Early update, rest is ignored
        idle_cycle();
        update_cycle();
      end
      cur = data[i];
      for (int j = 0; j < BYTE_W; j++) begin
        if (j == BYTE_W - 1) idle_cycle();  // PAUSE on the last bit of the byte
        shift_bit(cur[j], t);
      end
    end
    idle_cycle();
    update_cycle();
    exp = min3(u, f, (stop < n) ? stop : n);
    wait_writes(exp);
    idle_cycle();
    check_val({name, " write count"}, exp, wr_log.size());
    for (int i = 0; i < exp && i < wr_log.size(); i++) begin
      check_val($sformatf("%s byte %0d", name, i), data[i], wr_log[i]);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    void'($urandom(32'h86c2_a81c));
    value_errs      = 0;
    proto_errs      = 0;
    rd_strobes      = 0;
    timed_out       = 1'b0;
    dr_model        = '0;
    rst             = 1'b1;
    capture_dr      = 1'b0;
    shift_dr        = 1'b0;
    update_dr       = 1'b0;
    module_select   = 1'b1;  // Only device in the chain
    tdi             = 1'b0;
    biu_bytes_avail = '0;
    biu_space_free  = '0;
    repeat (10) @(posedge tck);
    #1 rst = 1'b0;
    check_val("reset tdo", 0, tdo);
    check_val("reset strobes", 0, {biu_wr_strobe, biu_rd_strobe});
    idle_cycle();

    read_test("read empty", 0, 2);
    read_test("read partial", 3, 5);
    read_test("read short", 6, 2);
    read_test("read full", 15, 16);
    for (int i = 0; i < 3; i++) begin
      read_test($sformatf("read rand %0d", i), $urandom_range(0, 15), $urandom_range(0, 8));
    end

    write_test("write basic", 4, 6, 4, 4);
    write_test("write space limit", 9, 3, 6, 6);
    write_test("write user limit", 2, 15, 5, 5);
    write_test("write user zero", 0, 8, 3, 3);
    write_test("write space zero", 7, 0, 3, 3);
    write_test("write abort", 6, 6, 5, 2);
    for (int i = 0; i < 3; i++) begin
      write_test($sformatf("write rand %0d", i), $urandom_range(0, 15),
                 $urandom_range(0, 15), $urandom_range(0, 10), 16);
    end

    $display("Errors: %0d value, %0d protocol, timeout %0d", value_errs, proto_errs,
             timed_out);
    if (value_errs == 0 && proto_errs == 0 && !timed_out) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Guard against a stuck run
  initial begin
    #100000;
    $display("Simulation ran past its time limit");
    $display("Test failures found");
    $finish;
  end

endmodule : tb_jsp_serial_port

/* flist.f */
rtl/jsp_cfg_pkg.sv
rtl/jsp_ctrl_pkg.sv
rtl/jsp_bit_counter.sv
rtl/jsp_word_counter.sv
rtl/jsp_out_shift.sv
rtl/jsp_wr_fsm.sv
rtl/jsp_rd_fsm.sv
rtl/jsp_serial_port.sv
verification/tb_jsp_serial_port.sv

/* Makefile */
# Verilator build and run of the JTAG serial port testbench

SIM = obj_dir/Vtb_jsp_serial_port

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): flist.f $(wildcard rtl/*.sv) $(wildcard verification/*.sv)
	verilator --binary --timing --assert --top-module tb_jsp_serial_port \
	  -f flist.f -o Vtb_jsp_serial_port

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log
